// ==== files.f ====
+incdir+include
+incdir+testbench
hdl/rv_decode_pkg.sv
hdl/inst_classify.sv
hdl/imm_gen.sv
hdl/ctrl_gen.sv
hdl/idu.sv
hdl/decode_perf_counters.sv
hdl/decode_top.sv
testbench/tb_decode_top.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module tb_decode_top -f files.f \
		-Mdir obj_dir -o tb_sim

run: build
	./obj_dir/tb_sim | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --top-module decode_top +incdir+include \
		hdl/rv_decode_pkg.sv hdl/inst_classify.sv hdl/imm_gen.sv hdl/ctrl_gen.sv \
		hdl/idu.sv hdl/decode_perf_counters.sv hdl/decode_top.sv

clean:
	rm -rf obj_dir sim.log

// ==== testbench/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// instruction words are built from fields in the standard RV32I layouts.
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm12, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm12, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_word(input logic [11:0] imm12, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'h23};
endfunction

function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

function automatic logic [31:0] sign_ext(input logic [31:0] v, input int w);
    logic signed [31:0] t;
    t = v << (32 - w);
    return t >>> (32 - w);
endfunction

// expected bundles for one instruction, from its op, format, immediate and pc.
task automatic expect_bundles(input logic [31:0] w, input logic [31:0] p, input rv_op_e op,
                              input rv_fmt_e fmt, input logic [31:0] imm,
                              output exu_ctrl_t ee, output gpr_ctrl_t eg,
                              output lsu_ctrl_t el, output wb_ctrl_t eb);
    ee = '0;
    eg = '0;
    el = '0;
    eb = '0;
    case (op)
        OP_ADD, OP_ADDI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
        OP_JAL, OP_JALR, OP_AUIPC: ee.alu_op = ALU_ADD;
        OP_SUB: ee.alu_op = ALU_SUB;
        OP_SLT: ee.alu_op = ALU_SLT;
        OP_SLTU, OP_SLTIU: ee.alu_op = ALU_SLTU;
        OP_AND, OP_ANDI: ee.alu_op = ALU_AND;
        OP_OR, OP_ORI: ee.alu_op = ALU_OR;
        OP_XOR, OP_XORI: ee.alu_op = ALU_XOR;
        OP_SLL, OP_SLLI: ee.alu_op = ALU_SLL;
        OP_SRL, OP_SRLI: ee.alu_op = ALU_SRL;
        OP_SRA, OP_SRAI: ee.alu_op = ALU_SRA;
        OP_LUI: ee.alu_op = ALU_LUI;
        OP_BEQ: ee.alu_op = ALU_BEQ;
        OP_BNE: ee.alu_op = ALU_BNE;
        OP_BLT: ee.alu_op = ALU_BLT;
        OP_BGE: ee.alu_op = ALU_BGE;
        OP_BLTU: ee.alu_op = ALU_BLTU;
        OP_BGEU: ee.alu_op = ALU_BGEU;
        default: ee.alu_op = ALU_NONE;
    endcase
    ee.imm = imm;
    ee.fmt = fmt;
    ee.src1_is_pc = op inside {OP_JAL, OP_AUIPC} || fmt == FMT_B;
    ee.src2_is_imm = fmt inside {FMT_I, FMT_S, FMT_B, FMT_U, FMT_J};
    // jumps, branches and the trap entry and return all redirect the pc.
    ee.is_pc_jump = op inside {OP_JAL, OP_JALR, OP_ECALL, OP_MRET} || fmt == FMT_B;
    ee.is_branch = fmt == FMT_B;
    ee.ebreak = op == OP_EBREAK;
    ee.illegal = op == OP_ILLEGAL;
    ee.ecall = op == OP_ECALL;
    ee.mret = op == OP_MRET;
    ee.csrrw = op == OP_CSRRW;
    ee.csrrs = op == OP_CSRRS;

    eg.pc = p;
    eg.rd = w[11:7];
    eg.rs1 = w[19:15];
    eg.rs2 = w[24:20];
    eg.ecall = op == OP_ECALL;
    eg.mret = op == OP_MRET;
    if (op inside {OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET}) begin
        case (imm[11:0])
            `CSR_MTVEC: eg.csr_sel = 6'b100000;
            `CSR_MEPC: eg.csr_sel = 6'b010000;
            `CSR_MSTATUS: eg.csr_sel = 6'b001000;
            `CSR_MCAUSE: eg.csr_sel = 6'b000100;
            `CSR_MVENDORID: eg.csr_sel = 6'b000010;
            `CSR_MARCHID: eg.csr_sel = 6'b000001;
            default: eg.csr_sel = 6'b000000;
        endcase
    end

    case (op)
        OP_LB, OP_LBU: el.load_size = 3'b001;
        OP_LH, OP_LHU: el.load_size = 3'b010;
        OP_LW: el.load_size = 3'b100;
        OP_SB: el.store_size = 3'b001;
        OP_SH: el.store_size = 3'b010;
        OP_SW: el.store_size = 3'b100;
        default: el.load = 1'b0;
    endcase
    el.load = el.load_size != 3'b000;
    el.store = el.store_size != 3'b000;

    eb.load_size = el.load_size;
    eb.byte_sext = op == OP_LB;
    eb.half_sext = op == OP_LH;
    eb.gpr_we = fmt == FMT_R ||
                op inside {OP_ADDI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI, OP_SRLI,
                           OP_SRAI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_JAL, OP_JALR,
                           OP_LUI, OP_AUIPC, OP_CSRRW, OP_CSRRS};
    eb.load = el.load;
    eb.csr_gpr_we = op inside {OP_CSRRW, OP_CSRRS};
endtask

// running per-format totals, with illegal words counted twice.
function automatic perf_counts_t tally(input perf_counts_t c, input rv_fmt_e fmt,
                                       input logic ill);
    case (fmt)
        FMT_R: c.r = c.r + 32'd1;
        FMT_I: c.i = c.i + 32'd1;
        FMT_S: c.s = c.s + 32'd1;
        FMT_B: c.b = c.b + 32'd1;
        FMT_U: c.u = c.u + 32'd1;
        FMT_J: c.j = c.j + 32'd1;
        default: c.n = c.n + 32'd1;
    endcase
    if (ill) begin
        c.illegal = c.illegal + 32'd1;
    end
    return c;
endfunction

`endif

// ==== testbench/tb_decode_top.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module tb_decode_top import rv_decode_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int N_INST = 63;
    localparam int N_STALLED = 8;
    localparam int MAX_STALL = 8;
    localparam int TIMEOUT = 4 * N_INST + MAX_STALL * N_STALLED + RESET_CYCLES;

    logic         clk;
    logic         rst;
    logic         in_valid;
    logic [31:0]  inst;
    logic [31:0]  pc;
    logic         in_ready;
    logic         out_ready;
    logic         out_valid;
    exu_ctrl_t    exu;
    gpr_ctrl_t    gpr;
    lsu_ctrl_t    lsu;
    wb_ctrl_t     wb;
    perf_counts_t counts;

    integer       seed;
    int           errors;
    int           checks;
    int           issued;
    int           cycles;
    int           stall_len;
    perf_counts_t exp_counts;

    `include "decode_model.svh"

    decode_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .inst      (inst),
        .pc        (pc),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .exu       (exu),
        .gpr       (gpr),
        .lsu       (lsu),
        .wb        (wb),
        .counts    (counts)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("checks %0d  errors %0d  instructions %0d", checks, errors, issued);
            $display("Something failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [255:0] got,
                           input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic wait_out_valid(output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!out_valid && n < 16);
        if (!out_valid) begin
            errors++;
            $display("out_valid never came within %0d cycles of the handoff", n);
        end
    endtask

    function automatic logic [11:0] rand12();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    function automatic logic [19:0] rand20();
        logic [31:0] r;
        r = $random(seed);
        return r[19:0];
    endfunction

    // one fetch to decode transfer, an optional stall, then the checked handoff.
    task automatic run_inst(input logic [31:0] w, input rv_op_e op, input rv_fmt_e fmt,
                            input logic [31:0] imm);
        logic [31:0] p;
        exu_ctrl_t   ee;
        gpr_ctrl_t   eg;
        lsu_ctrl_t   el;
        wb_ctrl_t    eb;
        int          n;
        p = $random(seed);
        p[1:0] = 2'b00;
        expect_bundles(w, p, op, fmt, imm, ee, eg, el, eb);
        exp_counts = tally(exp_counts, fmt, op == OP_ILLEGAL);
        issued++;
        @(posedge clk);
        in_valid <= 1'b1;
        inst <= w;
        pc <= p;
        out_ready <= (stall_len == 0);
        @(negedge clk);
        compare("in_ready", in_ready, 1);
        @(posedge clk);
        // the accept edge; during a stall fetch keeps offering a different word.
        in_valid <= (stall_len != 0);
        inst <= $random(seed);
        pc <= $random(seed);
        for (int k = 0; k < stall_len; k++) begin
            @(negedge clk);
            compare("in_ready", in_ready, 0);
            compare("out_valid", out_valid, 0);
            @(posedge clk);
        end
        in_valid <= 1'b0;
        out_ready <= 1'b1;
        wait_out_valid(n);
        compare("out_valid latency", n, 2);
        compare("in_ready", in_ready, 1);
        compare("exu", exu, ee);
        compare("gpr", gpr, eg);
        compare("lsu", lsu, el);
        compare("wb", wb, eb);
        @(negedge clk);
        compare("out_valid", out_valid, 0);
        compare("exu", exu, ee);
    endtask

    task automatic reg_form(input rv_op_e op, input logic [6:0] f7, input logic [2:0] f3);
        logic [31:0] r;
        r = $random(seed);
        run_inst(r_word(f7, r[14:10], r[9:5], f3, r[4:0], 7'h33), op, FMT_R, 32'd0);
    endtask

    task automatic imm_form(input rv_op_e op, input logic [6:0] opc, input logic [2:0] f3,
                            input logic [11:0] imm12);
        logic [31:0] r;
        r = $random(seed);
        run_inst(i_word(imm12, r[9:5], f3, r[4:0], opc), op, FMT_I,
                 sign_ext({20'd0, imm12}, 12));
    endtask

    task automatic store_form(input rv_op_e op, input logic [2:0] f3, input logic [11:0] imm12);
        logic [31:0] r;
        r = $random(seed);
        run_inst(s_word(imm12, r[14:10], r[9:5], f3), op, FMT_S, sign_ext({20'd0, imm12}, 12));
    endtask

    task automatic branch_form(input rv_op_e op, input logic [2:0] f3);
        logic [31:0] r;
        logic [12:0] off;
        r = $random(seed);
        off = {r[31:20], 1'b0};
        run_inst(b_word(off, r[14:10], r[9:5], f3), op, FMT_B, sign_ext({19'd0, off}, 13));
    endtask

    task automatic upper_form(input rv_op_e op, input logic [6:0] opc);
        logic [31:0] r;
        r = $random(seed);
        run_inst({r[31:12], r[4:0], opc}, op, FMT_U, {r[31:12], 12'd0});
    endtask

    task automatic jal_form();
        logic [31:0] r;
        logic [20:0] off;
        r = $random(seed);
        off = {rand20(), 1'b0};
        run_inst(j_word(off, r[4:0]), OP_JAL, FMT_J, sign_ext({11'd0, off}, 21));
    endtask

    task automatic after_reset();
        @(negedge clk);
        compare("in_ready", in_ready, 1);
        compare("out_valid", out_valid, 0);
        compare("exu", exu, '0);
        compare("gpr", gpr, '0);
        compare("lsu", lsu, '0);
        compare("wb", wb, '0);
        compare("counts", counts, '0);
    endtask

    task automatic alu_ops();
        logic [11:0] sh;
        reg_form(OP_ADD, 7'h00, 3'h0);
        reg_form(OP_SUB, 7'h20, 3'h0);
        reg_form(OP_SLL, 7'h00, 3'h1);
        reg_form(OP_SLT, 7'h00, 3'h2);
        reg_form(OP_SLTU, 7'h00, 3'h3);
        reg_form(OP_XOR, 7'h00, 3'h4);
        reg_form(OP_SRL, 7'h00, 3'h5);
        reg_form(OP_SRA, 7'h20, 3'h5);
        reg_form(OP_OR, 7'h00, 3'h6);
        reg_form(OP_AND, 7'h00, 3'h7);
        imm_form(OP_ADDI, 7'h13, 3'h0, rand12());
        imm_form(OP_SLTIU, 7'h13, 3'h3, rand12());
        imm_form(OP_XORI, 7'h13, 3'h4, rand12());
        imm_form(OP_ORI, 7'h13, 3'h6, rand12());
        imm_form(OP_ANDI, 7'h13, 3'h7, rand12());
        sh = rand12();
        imm_form(OP_SLLI, 7'h13, 3'h1, {7'h00, sh[4:0]});
        imm_form(OP_SRLI, 7'h13, 3'h5, {7'h00, sh[9:5]});
        imm_form(OP_SRAI, 7'h13, 3'h5, {7'h20, sh[4:0]});
    endtask

    task automatic loads_stores();
        imm_form(OP_LB, 7'h03, 3'h0, rand12());
        imm_form(OP_LH, 7'h03, 3'h1, rand12());
        imm_form(OP_LW, 7'h03, 3'h2, rand12());
        imm_form(OP_LBU, 7'h03, 3'h4, rand12());
        imm_form(OP_LHU, 7'h03, 3'h5, rand12());
        store_form(OP_SB, 3'h0, rand12());
        store_form(OP_SH, 3'h1, rand12());
        store_form(OP_SW, 3'h2, rand12());
    endtask

    task automatic control_flow();
        branch_form(OP_BEQ, 3'h0);
        branch_form(OP_BNE, 3'h1);
        branch_form(OP_BLT, 3'h4);
        branch_form(OP_BGE, 3'h5);
        branch_form(OP_BLTU, 3'h6);
        branch_form(OP_BGEU, 3'h7);
        jal_form();
        imm_form(OP_JALR, 7'h67, 3'h0, rand12());
        upper_form(OP_LUI, 7'h37);
        upper_form(OP_AUIPC, 7'h17);
    endtask

    task automatic csr_and_system();
        logic [11:0] addrs [6];
        addrs = '{`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE,
                  `CSR_MVENDORID, `CSR_MARCHID};
        for (int k = 0; k < 6; k++) begin
            imm_form(OP_CSRRW, 7'h73, 3'h1, addrs[k]);
            imm_form(OP_CSRRS, 7'h73, 3'h2, addrs[k]);
        end
        imm_form(OP_CSRRS, 7'h73, 3'h2, 12'h7c0);
        run_inst(32'h0000_0073, OP_ECALL, FMT_N, 32'd0);
        run_inst(32'h0010_0073, OP_EBREAK, FMT_N, 32'd0);
        run_inst(32'h3020_0073, OP_MRET, FMT_N, 32'd0);
        run_inst(32'h0000_0000, OP_WAIT, FMT_N, 32'd0);
        run_inst(32'hffff_ffff, OP_ILLEGAL, FMT_N, 32'd0);
        // a multiply word is outside the base set.
        run_inst(r_word(7'h01, 5'd3, 5'd2, 3'h0, 5'd1, 7'h33), OP_ILLEGAL, FMT_N, 32'd0);
    endtask

    task automatic back_pressure();
        for (int k = 0; k < N_STALLED; k++) begin
            stall_len = 1 + ($random(seed) & 7);
            if (k % 2 == 0) begin
                imm_form(OP_ADDI, 7'h13, 3'h0, rand12());
            end else begin
                store_form(OP_SW, 3'h2, rand12());
            end
        end
        stall_len = 0;
    endtask

    initial begin
        seed = 32'h8d20_1446;
        errors = 0;
        checks = 0;
        issued = 0;
        cycles = 0;
        stall_len = 0;
        exp_counts = '0;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        inst = 32'd0;
        pc = 32'd0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        after_reset();
        alu_ops();
        loads_stores();
        control_flow();
        csr_and_system();
        back_pressure();
        compare("counts", counts, exp_counts);
        $display("checks %0d  errors %0d  instructions %0d", checks, errors, issued);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== hdl/decode_top.sv ====
`timescale 1ns/1ps

module decode_top import rv_decode_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  logic [31:0]  inst,
    input  logic [31:0]  pc,
    output logic         in_ready,
    input  logic         out_ready,
    output logic         out_valid,
    output exu_ctrl_t    exu,
    output gpr_ctrl_t    gpr,
    output lsu_ctrl_t    lsu,
    output wb_ctrl_t     wb,
    output perf_counts_t counts
);

    idu u_idu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .inst      (inst),
        .pc        (pc),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .exu       (exu),
        .gpr       (gpr),
        .lsu       (lsu),
        .wb        (wb)
    );

    decode_perf_counters u_perf (
        .clk       (clk),
        .rst       (rst),
        .out_valid (out_valid),
        .exu       (exu),
        .counts    (counts)
    );

endmodule

// ==== hdl/decode_perf_counters.sv ====
`timescale 1ns/1ps

module decode_perf_counters import rv_decode_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         out_valid,
    input  exu_ctrl_t    exu,
    output perf_counts_t counts
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counts <= '0;
        end else if (out_valid) begin
            case (exu.fmt)
                FMT_R: counts.r <= counts.r + 1'b1;
                FMT_I: counts.i <= counts.i + 1'b1;
                FMT_S: counts.s <= counts.s + 1'b1;
                FMT_B: counts.b <= counts.b + 1'b1;
                FMT_U: counts.u <= counts.u + 1'b1;
                FMT_J: counts.j <= counts.j + 1'b1;
                default: counts.n <= counts.n + 1'b1;
            endcase
            // illegal words also land in the N bucket above.
            if (exu.illegal) begin
                counts.illegal <= counts.illegal + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/idu.sv ====
`timescale 1ns/1ps

module idu import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    output logic        in_ready,
    input  logic        out_ready,
    output logic        out_valid,
    output exu_ctrl_t   exu,
    output gpr_ctrl_t   gpr,
    output lsu_ctrl_t   lsu,
    output wb_ctrl_t    wb
);

    dec_state_e  state;
    logic [31:0] inst_q;
    logic [31:0] pc_q;
    logic        accept;
    logic        handoff;
    rv_op_e      op;
    rv_fmt_e     fmt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    exu_ctrl_t   exu_d;
    gpr_ctrl_t   gpr_d;
    lsu_ctrl_t   lsu_d;
    wb_ctrl_t    wb_d;

    assign in_ready = (state == DEC_IDLE);
    assign accept   = in_valid && in_ready;
    assign handoff  = (state == DEC_BUSY) && out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DEC_IDLE;
        end else if (accept) begin
            state <= DEC_BUSY;
        end else if (handoff) begin
            state <= DEC_IDLE;
        end
    end

    // instruction and pc are taken together on the accept edge.
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= inst;
            pc_q   <= pc;
        end
    end

    inst_classify u_classify (
        .inst (inst_q),
        .op   (op),
        .fmt  (fmt),
        .rd   (rd),
        .rs1  (rs1),
        .rs2  (rs2)
    );

    imm_gen u_imm (
        .inst (inst_q),
        .fmt  (fmt),
        .imm  (imm)
    );

    ctrl_gen u_ctrl (
        .op   (op),
        .fmt  (fmt),
        .imm  (imm),
        .pc   (pc_q),
        .rd   (rd),
        .rs1  (rs1),
        .rs2  (rs2),
        .exu  (exu_d),
        .gpr  (gpr_d),
        .lsu  (lsu_d),
        .wb   (wb_d)
    );

    // out_valid is high for the single cycle after the handoff edge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            exu       <= '0;
            gpr       <= '0;
            lsu       <= '0;
            wb        <= '0;
        end else begin
            out_valid <= handoff;
            if (handoff) begin
                exu <= exu_d;
                gpr <= gpr_d;
                lsu <= lsu_d;
                wb  <= wb_d;
            end
        end
    end

endmodule

// ==== hdl/ctrl_gen.sv ====
`timescale 1ns/1ps
`include "rv_decode_macros.svh"

module ctrl_gen import rv_decode_pkg::*; (
    input  rv_op_e              op,
    input  rv_fmt_e             fmt,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [4:0]          rd,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output exu_ctrl_t           exu,
    output gpr_ctrl_t           gpr,
    output lsu_ctrl_t           lsu,
    output wb_ctrl_t            wb
);

    alu_op_e    alu_op;
    logic       is_load;
    logic       is_store;
    logic       is_csr_op;
    logic [2:0] load_size;
    logic [2:0] store_size;
    logic [11:0] csr_addr;

    // loads, stores and jumps all compute an address with the adder.
    always_comb begin
        case (op)
            OP_ADD, OP_ADDI, OP_AUIPC, OP_JAL, OP_JALR,
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_SB, OP_SH, OP_SW: alu_op = ALU_ADD;
            OP_SUB: alu_op = ALU_SUB;
            OP_SLT: alu_op = ALU_SLT;
            OP_SLTU, OP_SLTIU: alu_op = ALU_SLTU;
            OP_AND, OP_ANDI: alu_op = ALU_AND;
            OP_OR, OP_ORI: alu_op = ALU_OR;
            OP_XOR, OP_XORI: alu_op = ALU_XOR;
            OP_SLL, OP_SLLI: alu_op = ALU_SLL;
            OP_SRL, OP_SRLI: alu_op = ALU_SRL;
            OP_SRA, OP_SRAI: alu_op = ALU_SRA;
            OP_LUI: alu_op = ALU_LUI;
            OP_BEQ: alu_op = ALU_BEQ;
            OP_BNE: alu_op = ALU_BNE;
            OP_BLT: alu_op = ALU_BLT;
            OP_BGE: alu_op = ALU_BGE;
            OP_BLTU: alu_op = ALU_BLTU;
            OP_BGEU: alu_op = ALU_BGEU;
            default: alu_op = ALU_NONE;
        endcase
    end

    assign load_size  = {op == OP_LW, op == OP_LH || op == OP_LHU, op == OP_LB || op == OP_LBU};
    assign store_size = {op == OP_SW, op == OP_SH, op == OP_SB};
    assign is_load    = |load_size;
    assign is_store   = |store_size;
    assign is_csr_op  = op == OP_CSRRW || op == OP_CSRRS || op == OP_ECALL || op == OP_MRET;
    assign csr_addr   = imm[11:0];

    always_comb begin
        exu.imm         = imm;
        exu.alu_op      = alu_op;
        exu.fmt         = fmt;
        exu.src1_is_pc  = op == OP_JAL || op == OP_AUIPC || fmt == FMT_B;
        exu.src2_is_imm = fmt != FMT_R && fmt != FMT_N;
        exu.is_pc_jump  = op == OP_JAL || op == OP_JALR || fmt == FMT_B ||
                          op == OP_ECALL || op == OP_MRET;
        exu.is_branch   = fmt == FMT_B;
        exu.ebreak      = op == OP_EBREAK;
        exu.illegal     = op == OP_ILLEGAL;
        exu.ecall       = op == OP_ECALL;
        exu.mret        = op == OP_MRET;
        exu.csrrw       = op == OP_CSRRW;
        exu.csrrs       = op == OP_CSRRS;

        gpr.pc      = pc;
        gpr.rd      = rd;
        gpr.rs1     = rs1;
        gpr.rs2     = rs2;
        gpr.csr_sel = {csr_addr == `CSR_MTVEC, csr_addr == `CSR_MEPC,
                       csr_addr == `CSR_MSTATUS, csr_addr == `CSR_MCAUSE,
                       csr_addr == `CSR_MVENDORID, csr_addr == `CSR_MARCHID} & {6{is_csr_op}};
        gpr.ecall   = op == OP_ECALL;
        gpr.mret    = op == OP_MRET;

        lsu.load_size  = load_size;
        lsu.store_size = store_size;
        lsu.load       = is_load;
        lsu.store      = is_store;

        // every I-format op except fence.i writes a register.
        wb.load_size  = load_size;
        wb.byte_sext  = op == OP_LB;
        wb.half_sext  = op == OP_LH;
        wb.gpr_we     = fmt == FMT_R || fmt == FMT_U || fmt == FMT_J ||
                        (fmt == FMT_I && op != OP_FENCE_I);
        wb.load       = is_load;
        wb.csr_gpr_we = op == OP_CSRRW || op == OP_CSRRS;
    end

endmodule

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen import rv_decode_pkg::*; (
    input  logic [31:0] inst,
    input  rv_fmt_e     fmt,
    output logic [31:0] imm
);

    always_comb begin
        case (fmt)
            FMT_I: imm = {{20{inst[31]}}, inst[31:20]};
            FMT_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U: imm = {inst[31:12], 12'd0};
            FMT_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            // R and N formats carry no immediate.
            default: imm = 32'd0;
        endcase
    end

endmodule

// ==== hdl/inst_classify.sv ====
`timescale 1ns/1ps

module inst_classify import rv_decode_pkg::*; (
    input  logic [31:0] inst,
    output rv_op_e      op,
    output rv_fmt_e     fmt,
    output logic [4:0]  rd,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    logic       sys_zero;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign funct6 = inst[31:26];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // rd and rs1 both zero, shared by the system and fence.i checks.
    assign sys_zero = (rd == 5'd0) && (rs1 == 5'd0);

    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            7'h33: begin
                case (funct3)
                    3'h0: op = (funct7 == 7'h00) ? OP_ADD :
                               (funct7 == 7'h20) ? OP_SUB : OP_ILLEGAL;
                    3'h1: op = (funct7 == 7'h00) ? OP_SLL : OP_ILLEGAL;
                    3'h2: op = (funct7 == 7'h00) ? OP_SLT : OP_ILLEGAL;
                    3'h3: op = (funct7 == 7'h00) ? OP_SLTU : OP_ILLEGAL;
                    3'h4: op = (funct7 == 7'h00) ? OP_XOR : OP_ILLEGAL;
                    // shifts check funct6 only.
                    3'h5: op = (funct6 == 6'h00) ? OP_SRL :
                               (funct6 == 6'h10) ? OP_SRA : OP_ILLEGAL;
                    3'h6: op = (funct7 == 7'h00) ? OP_OR : OP_ILLEGAL;
                    default: op = (funct7 == 7'h00) ? OP_AND : OP_ILLEGAL;
                endcase
            end
            7'h13: begin
                case (funct3)
                    3'h0: op = OP_ADDI;
                    3'h1: op = (funct6 == 6'h00) ? OP_SLLI : OP_ILLEGAL;
                    3'h3: op = OP_SLTIU;
                    3'h4: op = OP_XORI;
                    3'h5: op = (funct6 == 6'h00) ? OP_SRLI :
                               (funct6 == 6'h10) ? OP_SRAI : OP_ILLEGAL;
                    3'h6: op = OP_ORI;
                    3'h7: op = OP_ANDI;
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'h03: begin
                case (funct3)
                    3'h0: op = OP_LB;
                    3'h1: op = OP_LH;
                    3'h2: op = OP_LW;
                    3'h4: op = OP_LBU;
                    3'h5: op = OP_LHU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'h23: begin
                case (funct3)
                    3'h0: op = OP_SB;
                    3'h1: op = OP_SH;
                    3'h2: op = OP_SW;
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'h63: begin
                case (funct3)
                    3'h0: op = OP_BEQ;
                    3'h1: op = OP_BNE;
                    3'h4: op = OP_BLT;
                    3'h5: op = OP_BGE;
                    3'h6: op = OP_BLTU;
                    3'h7: op = OP_BGEU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'h37: op = OP_LUI;
            7'h17: op = OP_AUIPC;
            7'h6f: op = OP_JAL;
            7'h67: op = (funct3 == 3'h0) ? OP_JALR : OP_ILLEGAL;
            7'h0f: begin
                if (sys_zero && funct3 == 3'h1 && rs2 == 5'd0 && funct7 == 7'h00) begin
                    op = OP_FENCE_I;
                end
            end
            7'h73: begin
                if (funct3 == 3'h1) begin
                    op = OP_CSRRW;
                end else if (funct3 == 3'h2) begin
                    op = OP_CSRRS;
                end else if (funct3 == 3'h0 && sys_zero) begin
                    if (funct7 == 7'h00 && rs2 == 5'd0) begin
                        op = OP_ECALL;
                    end else if (funct7 == 7'h00 && rs2 == 5'd1) begin
                        op = OP_EBREAK;
                    end else if (funct7 == 7'h18 && rs2 == 5'd2) begin
                        op = OP_MRET;
                    end
                end
            end
            7'h00: op = (inst == 32'd0) ? OP_WAIT : OP_ILLEGAL;
            default: op = OP_ILLEGAL;
        endcase
    end

    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
            OP_SLL, OP_SRL, OP_SRA: fmt = FMT_R;
            OP_ADDI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI, OP_SRLI, OP_SRAI,
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_JALR,
            OP_CSRRW, OP_CSRRS, OP_FENCE_I: fmt = FMT_I;
            OP_SB, OP_SH, OP_SW: fmt = FMT_S;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: fmt = FMT_B;
            OP_LUI, OP_AUIPC: fmt = FMT_U;
            OP_JAL: fmt = FMT_J;
            default: fmt = FMT_N;
        endcase
    end

endmodule

// ==== hdl/rv_decode_pkg.sv ====
`include "rv_decode_macros.svh"

package rv_decode_pkg;

    // one value per decoded instruction.
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADDI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET, OP_EBREAK, OP_FENCE_I,
        OP_WAIT, OP_ILLEGAL
    } rv_op_e;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_N
    } rv_fmt_e;

    typedef enum logic {
        DEC_IDLE, DEC_BUSY
    } dec_state_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_NONE
    } alu_op_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] imm;
        alu_op_e             alu_op;
        rv_fmt_e             fmt;
        logic                src1_is_pc;
        logic                src2_is_imm;
        logic                is_pc_jump;
        logic                is_branch;
        logic                ebreak;
        logic                illegal;
        logic                ecall;
        logic                mret;
        logic                csrrw;
        logic                csrrs;
    } exu_ctrl_t;

    // csr_sel bits from 5 down to 0 are mtvec, mepc, mstatus, mcause, mvendorid, marchid.
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [5:0]          csr_sel;
        logic                ecall;
        logic                mret;
    } gpr_ctrl_t;

    // size one-hots are {word, half, byte}.
    typedef struct packed {
        logic [2:0] load_size;
        logic [2:0] store_size;
        logic       load;
        logic       store;
    } lsu_ctrl_t;

    typedef struct packed {
        logic [2:0] load_size;
        logic       byte_sext;
        logic       half_sext;
        logic       gpr_we;
        logic       load;
        logic       csr_gpr_we;
    } wb_ctrl_t;

    typedef struct packed {
        logic [`PERF_CNT_W-1:0] r;
        logic [`PERF_CNT_W-1:0] i;
        logic [`PERF_CNT_W-1:0] s;
        logic [`PERF_CNT_W-1:0] b;
        logic [`PERF_CNT_W-1:0] u;
        logic [`PERF_CNT_W-1:0] j;
        logic [`PERF_CNT_W-1:0] n;
        logic [`PERF_CNT_W-1:0] illegal;
    } perf_counts_t;

endpackage

// ==== include/rv_decode_macros.svh ====
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// data path width of the core.
`define RV_XLEN 32

// machine CSR addresses recognized by the decoder.
`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12

// width of each decode performance counter.
`define PERF_CNT_W 32

`endif
